//--- lpc_sniffer_pkg.sv
package lpc_sniffer_pkg;

	// ******************************
	// lpc cycle type / direction
	// ******************************

	// values are the cyctype nibble as seen on lpc_ad
	typedef enum logic [3:0] {
		cyc_io_read   = 4'b0000,
		cyc_io_write  = 4'b0010,
		cyc_mem_read  = 4'b0100,
		cyc_mem_write = 4'b0110
	} lpc_cyc_e;

	// one decoded cycle, byte 0 (kind) is the top byte
	typedef struct packed {
		logic [3:0] kind_pad;
		lpc_cyc_e kind;
		logic [31:0] addr; // io cycles use the low 16 bits
		logic [7:0] data;
	} lpc_rec_t;

	// ******************************
	// record ram
	// ******************************

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic we;
	} mem_req_t;

	localparam int REC_BYTES = 6; // bytes written per record
	localparam int SLOT_SHIFT = 3; // 8 byte slots, top 2 bytes unused

endpackage

//--- lpc_decoder.sv
`timescale 1ns/1ps

module lpc_decoder (
	input logic clock,
	input logic rst,
	input logic [3:0] lpc_ad,
	input logic lpc_frame, // active low
	output logic rec_valid,
	output lpc_sniffer_pkg::lpc_rec_t rec,
	input logic rec_ready
);

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_cyctype,
		st_addr,
		st_wdata,
		st_tar,
		st_sync,
		st_rdata
	} state_e;

	localparam logic [3:0] START_TARGET = 4'b0000;
	localparam logic [3:0] SYNC_READY = 4'b0000;
	localparam logic [3:0] SYNC_SHORT_WAIT = 4'b0101;

	state_e state;
	logic [2:0] cnt; // nibble counter inside a phase
	logic [3:0] cyc_q;
	logic [31:0] addr_q;
	logic [3:0] data_lo;
	logic cyc_ok;
	logic [2:0] addr_last;

	always_comb begin
		case (cyc_q)
		lpc_sniffer_pkg::cyc_io_read, lpc_sniffer_pkg::cyc_io_write,
		lpc_sniffer_pkg::cyc_mem_read, lpc_sniffer_pkg::cyc_mem_write:
			cyc_ok = 1'b1;
		default:
			cyc_ok = 1'b0; // dma, firmware, bus master
		endcase
	end

	assign addr_last = cyc_q[2] ? 3'd7 : 3'd3; // bit 2 marks memory cycles

	// ******************************
	// control
	// ******************************
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_idle;
			cnt <= '0;
			rec_valid <= 1'b0;
		end else begin
			if (rec_valid && rec_ready)
				rec_valid <= 1'b0;
			if (!lpc_frame) begin
				// start of a cycle, or an abort of the one running
				state <= (lpc_ad == START_TARGET) ? st_start : st_idle;
			end else begin
				case (state)
				st_idle: state <= st_idle;
				st_start: state <= st_cyctype;
				st_cyctype: begin
					cnt <= 3'd1; // first address nibble is on the bus now
					state <= cyc_ok ? st_addr : st_idle;
				end
				st_addr: begin
					cnt <= cnt + 3'd1;
					if (cnt == addr_last) begin
						cnt <= '0;
						state <= cyc_q[1] ? st_wdata : st_tar; // bit 1 marks writes
					end
				end
				st_wdata: begin
					cnt <= cnt + 3'd1;
					if (cnt == 3'd1) begin
						rec_valid <= 1'b1;
						state <= st_idle; // host tar and sync are not needed
					end
				end
				st_tar: begin
					cnt <= cnt + 3'd1;
					if (cnt == 3'd1)
						state <= st_sync;
				end
				st_sync: begin
					cnt <= '0;
					if (lpc_ad == SYNC_READY)
						state <= st_rdata;
					else if (lpc_ad != SYNC_SHORT_WAIT)
						state <= st_idle;
				end
				st_rdata: begin
					cnt <= cnt + 3'd1;
					if (cnt == 3'd1) begin
						rec_valid <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
				endcase
			end
		end
	end

	// ******************************
	// nibble capture
	// ******************************
	always_ff @(posedge clock) begin
		if (lpc_frame) begin
			case (state)
			st_start: cyc_q <= lpc_ad;
			st_cyctype: addr_q <= {28'h0, lpc_ad};
			st_addr: addr_q <= {addr_q[27:0], lpc_ad}; // msb nibble first
			st_wdata, st_rdata: begin
				if (cnt == 3'd0) begin
					data_lo <= lpc_ad; // low nibble comes first
				end else begin
					rec.kind_pad <= '0;
					rec.kind <= lpc_sniffer_pkg::lpc_cyc_e'(cyc_q);
					rec.addr <= addr_q;
					rec.data <= {lpc_ad, data_lo};
				end
			end
			default: ;
			endcase
		end
	end

endmodule

//--- capture_writer.sv
`timescale 1ns/1ps

module capture_writer #(
	parameter SLOT_BITS = 5
) (
	input logic clock,
	input logic rst,
	input logic rec_valid,
	input lpc_sniffer_pkg::lpc_rec_t rec,
	output logic rec_ready,
	input logic [SLOT_BITS-1:0] wr_slot,
	input logic full,
	output logic commit,
	output logic drop,
	output logic req_valid,
	output lpc_sniffer_pkg::mem_req_t req,
	input logic req_ready
);

	localparam int IDX_BITS = lpc_sniffer_pkg::SLOT_SHIFT;
	localparam int ADDR_BITS = SLOT_BITS + IDX_BITS;
	localparam int REC_W = $bits(lpc_sniffer_pkg::lpc_rec_t);
	localparam logic [IDX_BITS-1:0] LAST_BYTE = IDX_BITS'(lpc_sniffer_pkg::REC_BYTES - 1);

	logic busy;
	logic [IDX_BITS-1:0] idx;
	logic [REC_W-1:0] bytes_q; // next byte to write sits in the top 8 bits
	logic [ADDR_BITS-1:0] byte_addr;

	assign rec_ready = !busy && !commit && !drop; // ring state settles after commit/drop
	assign req_valid = busy;
	assign byte_addr = {wr_slot, idx};

	always_comb begin
		req = '0;
		req.addr[ADDR_BITS-1:0] = byte_addr; // slot base plus byte index
		req.wdata = bytes_q[REC_W-1 -: 8];
		req.we = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			idx <= '0;
			commit <= 1'b0;
			drop <= 1'b0;
		end else begin
			commit <= 1'b0;
			drop <= 1'b0;
			if (rec_valid && rec_ready) begin
				if (full) begin
					drop <= 1'b1; // ring full, record lost
				end else begin
					busy <= 1'b1;
					idx <= '0;
				end
			end else if (busy && req_ready) begin
				idx <= idx + 1'b1;
				if (idx == LAST_BYTE) begin
					busy <= 1'b0;
					commit <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rec_valid && rec_ready)
			bytes_q <= rec;
		else if (busy && req_ready)
			bytes_q <= {bytes_q[REC_W-9:0], 8'h00};
	end

endmodule

//--- ring_ctrl.sv
`timescale 1ns/1ps

module ring_ctrl #(
	parameter SLOT_BITS = 5
) (
	input logic clock,
	input logic rst,
	input logic commit,
	input logic release_slot,
	input logic drop,
	output logic [SLOT_BITS-1:0] wr_slot,
	output logic [SLOT_BITS-1:0] rd_slot,
	output logic empty,
	output logic full,
	output logic overflow
);

	logic [SLOT_BITS:0] count; // one extra bit so full != empty

	assign empty = (count == '0);
	assign full = count[SLOT_BITS];

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_slot <= '0;
			rd_slot <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (commit)
				wr_slot <= wr_slot + 1'b1;
			if (release_slot)
				rd_slot <= rd_slot + 1'b1;
			if (commit && !release_slot)
				count <= count + 1'b1;
			else if (!commit && release_slot)
				count <= count - 1'b1;
			if (drop)
				overflow <= 1'b1; // sticky until reset
		end
	end

endmodule

//--- record_ram.sv
`timescale 1ns/1ps

module record_ram #(
	parameter ADDR_BITS = 8
) (
	input logic clock,
	input lpc_sniffer_pkg::mem_req_t req,
	input logic en,
	output logic [7:0] rd_data
);

	logic [7:0] mem [2**ADDR_BITS];
	logic [ADDR_BITS-1:0] addr;

	assign addr = req.addr[ADDR_BITS-1:0];

	always_ff @(posedge clock) begin
		if (en) begin
			if (req.we)
				mem[addr] <= req.wdata;
			rd_data <= mem[addr]; // read data one cycle later
		end
	end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
	parameter SLOT_BITS = 5
) (
	input logic clock,
	input logic rst,
	input logic wr_req_valid,
	input lpc_sniffer_pkg::mem_req_t wr_req,
	output logic wr_req_ready,
	input logic rd_req_valid,
	input lpc_sniffer_pkg::mem_req_t rd_req,
	output logic rd_req_ready,
	output logic [7:0] rd_data,
	output logic rd_valid
);

	logic wr_grant;
	logic rd_grant;
	logic ram_en;
	lpc_sniffer_pkg::mem_req_t ram_req;

	// ******************************
	// fixed priority, writer first
	// ******************************
	assign wr_req_ready = 1'b1; // capture side is never stalled
	assign rd_req_ready = !wr_req_valid;
	assign wr_grant = wr_req_valid && wr_req_ready;
	assign rd_grant = rd_req_valid && rd_req_ready;

	assign ram_en = wr_grant || rd_grant;
	assign ram_req = wr_grant ? wr_req : rd_req;

	always_ff @(posedge clock) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_grant && !rd_req.we; // lines up with registered ram data
	end

	record_ram #(
		.ADDR_BITS(SLOT_BITS + lpc_sniffer_pkg::SLOT_SHIFT)
	) ram0 (
		.clock(clock),
		.req(ram_req),
		.en(ram_en),
		.rd_data(rd_data)
	);

endmodule

//--- record_serializer.sv
`timescale 1ns/1ps

module record_serializer #(
	parameter SLOT_BITS = 5
) (
	input logic clock,
	input logic rst,
	input logic empty,
	input logic [SLOT_BITS-1:0] rd_slot,
	output logic release_slot,
	output logic req_valid,
	output lpc_sniffer_pkg::mem_req_t req,
	input logic req_ready,
	input logic [7:0] rd_data,
	input logic rd_valid,
	output logic tx_valid,
	output logic [7:0] tx_byte,
	input logic tx_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_wait,
		st_send
	} state_e;

	localparam int IDX_BITS = lpc_sniffer_pkg::SLOT_SHIFT;
	localparam int ADDR_BITS = SLOT_BITS + IDX_BITS;
	localparam logic [IDX_BITS-1:0] LAST_BYTE = IDX_BITS'(lpc_sniffer_pkg::REC_BYTES - 1);

	state_e state;
	logic [IDX_BITS-1:0] idx;
	logic [7:0] byte_q;

	assign req_valid = (state == st_read);
	assign tx_valid = (state == st_send);
	assign tx_byte = byte_q;

	always_comb begin
		req = '0;
		req.addr[ADDR_BITS-1:0] = {rd_slot, idx};
		req.we = 1'b0; // read only port
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_idle;
			idx <= '0;
			release_slot <= 1'b0;
		end else begin
			release_slot <= 1'b0;
			case (state)
			st_idle: begin
				// empty is stale while the last release is in flight
				if (!empty && !release_slot) begin
					idx <= '0;
					state <= st_read;
				end
			end
			st_read: if (req_ready) state <= st_wait;
			st_wait: if (rd_valid) state <= st_send;
			st_send: begin
				if (tx_ready) begin
					if (idx == LAST_BYTE) begin
						release_slot <= 1'b1;
						state <= st_idle;
					end else begin
						idx <= idx + 1'b1;
						state <= st_read;
					end
				end
			end
			default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_wait && rd_valid)
			byte_q <= rd_data;
	end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter CLOCK_FREQ = 12000000,
	parameter BAUD_RATE = 115200
) (
	input logic clock,
	input logic rst,
	input logic tx_valid,
	input logic [7:0] tx_byte,
	output logic tx_ready,
	output logic tx
);

	localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_BITS = $clog2(CLOCKS_PER_BIT + 1);
	localparam logic [CNT_BITS-1:0] BAUD_LAST = CNT_BITS'(CLOCKS_PER_BIT - 1);
	localparam logic [3:0] STOP_BIT = 4'd9;

	logic busy;
	logic [CNT_BITS-1:0] baud_cnt;
	logic [3:0] bit_cnt; // 0 start, 1..8 data, 9 stop
	logic [8:0] shift_q; // data lsb first, then the stop bit

	assign tx_ready = !busy;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			tx <= 1'b1; // line idles high
		end else if (!busy) begin
			if (tx_valid) begin
				busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
				tx <= 1'b0; // start bit
			end
		end else if (baud_cnt == BAUD_LAST) begin
			baud_cnt <= '0;
			bit_cnt <= bit_cnt + 4'd1;
			if (bit_cnt == STOP_BIT)
				busy <= 1'b0;
			else
				tx <= shift_q[0];
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!busy && tx_valid)
			shift_q <= {1'b1, tx_byte};
		else if (busy && baud_cnt == BAUD_LAST)
			shift_q <= {1'b1, shift_q[8:1]};
	end

endmodule

//--- lpc_sniffer.sv
`timescale 1ns/1ps

module lpc_sniffer #(
	parameter CLOCK_FREQ = 12000000,
	parameter BAUD_RATE = 115200,
	parameter SLOT_BITS = 5
) (
	input logic clock,
	input logic rst,
	input logic [3:0] lpc_ad,
	input logic lpc_frame,
	output logic uart_tx,
	output logic overflow
);

	// decoder -> writer
	logic rec_valid;
	logic rec_ready;
	lpc_sniffer_pkg::lpc_rec_t rec;

	// ******************************
	// ring pointers and flags
	// ******************************
	logic [SLOT_BITS-1:0] wr_slot;
	logic [SLOT_BITS-1:0] rd_slot;
	logic empty;
	logic full;
	logic commit;
	logic drop;
	logic release_slot;

	// memory ports
	logic wr_req_valid;
	logic wr_req_ready;
	lpc_sniffer_pkg::mem_req_t wr_req;
	logic rd_req_valid;
	logic rd_req_ready;
	lpc_sniffer_pkg::mem_req_t rd_req;
	logic [7:0] rd_data;
	logic rd_valid;

	// serializer -> uart
	logic tx_valid;
	logic tx_ready;
	logic [7:0] tx_byte;

	lpc_decoder decoder0 (
		.clock(clock), .rst(rst),
		.lpc_ad(lpc_ad), .lpc_frame(lpc_frame),
		.rec_valid(rec_valid), .rec(rec), .rec_ready(rec_ready)
	);

	capture_writer #(.SLOT_BITS(SLOT_BITS)) writer0 (
		.clock(clock), .rst(rst),
		.rec_valid(rec_valid), .rec(rec), .rec_ready(rec_ready),
		.wr_slot(wr_slot), .full(full), .commit(commit), .drop(drop),
		.req_valid(wr_req_valid), .req(wr_req), .req_ready(wr_req_ready)
	);

	ring_ctrl #(.SLOT_BITS(SLOT_BITS)) ring0 (
		.clock(clock), .rst(rst),
		.commit(commit), .release_slot(release_slot), .drop(drop),
		.wr_slot(wr_slot), .rd_slot(rd_slot),
		.empty(empty), .full(full), .overflow(overflow)
	);

	mem_arbiter #(.SLOT_BITS(SLOT_BITS)) arbiter0 (
		.clock(clock), .rst(rst),
		.wr_req_valid(wr_req_valid), .wr_req(wr_req), .wr_req_ready(wr_req_ready),
		.rd_req_valid(rd_req_valid), .rd_req(rd_req), .rd_req_ready(rd_req_ready),
		.rd_data(rd_data), .rd_valid(rd_valid)
	);

	record_serializer #(.SLOT_BITS(SLOT_BITS)) serializer0 (
		.clock(clock), .rst(rst),
		.empty(empty), .rd_slot(rd_slot), .release_slot(release_slot),
		.req_valid(rd_req_valid), .req(rd_req), .req_ready(rd_req_ready),
		.rd_data(rd_data), .rd_valid(rd_valid),
		.tx_valid(tx_valid), .tx_byte(tx_byte), .tx_ready(tx_ready)
	);

	uart_tx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) serial0 (
		.clock(clock), .rst(rst),
		.tx_valid(tx_valid), .tx_byte(tx_byte), .tx_ready(tx_ready),
		.tx(uart_tx)
	);

endmodule

//--- lpc_sniffer_chk.sv
`timescale 1ns/1ps

module lpc_sniffer_chk (
	input logic clock,
	input logic rst,
	input logic rec_valid,
	input logic rec_ready,
	input lpc_sniffer_pkg::lpc_rec_t rec,
	input logic wr_req_valid,
	input logic wr_req_ready,
	input logic rd_req_valid,
	input logic rd_req_ready,
	input logic overflow,
	input logic tx_ready,
	input logic uart_tx
);

	// shortest lpc cycle is 13 clocks, so a record must be taken well before that
	localparam int MAX_PENDING = 8;

	int fail_count = 0; // read by the testbench at the end of the run
	int pending; // clocks a record has waited for rec_ready

	always_ff @(posedge clock) begin
		if (rst || !rec_valid || rec_ready)
			pending <= 0;
		else
			pending <= pending + 1;
	end

	// ******************************
	// decoder to writer
	// ******************************
	rec_held: assert property (@(posedge clock) disable iff (rst)
		rec_valid && !rec_ready |=> rec_valid && $stable(rec))
	else begin
		fail_count++;
		$error("record changed or vanished before the writer took it");
	end

	rec_taken: assert property (@(posedge clock) disable iff (rst)
		pending < MAX_PENDING)
	else begin
		fail_count++;
		$error("record pending too long, next lpc cycle could complete on top of it");
	end

	// ******************************
	// ram ports, flags, line
	// ******************************
	one_grant: assert property (@(posedge clock) disable iff (rst)
		!(wr_req_valid && wr_req_ready && rd_req_valid && rd_req_ready))
	else begin
		fail_count++;
		$error("writer and serializer granted in the same cycle");
	end

	overflow_sticky: assert property (@(posedge clock) disable iff (rst)
		overflow |=> overflow)
	else begin
		fail_count++;
		$error("overflow fell without reset");
	end

	line_idle: assert property (@(posedge clock) disable iff (rst)
		tx_ready |-> uart_tx)
	else begin
		fail_count++;
		$error("uart line low while the transmitter is idle");
	end

endmodule

bind lpc_sniffer lpc_sniffer_chk chk0 (
	.clock(clock),
	.rst(rst),
	.rec_valid(rec_valid),
	.rec_ready(rec_ready),
	.rec(rec),
	.wr_req_valid(wr_req_valid),
	.wr_req_ready(wr_req_ready),
	.rd_req_valid(rd_req_valid),
	.rd_req_ready(rd_req_ready),
	.overflow(overflow),
	.tx_ready(tx_ready),
	.uart_tx(uart_tx)
);

//--- tb_lpc_sniffer.sv
`timescale 1ns/1ps

module tb_lpc_sniffer;

	localparam int CLOCK_FREQ = 1000000;
	localparam int BAUD_RATE = 250000;
	localparam int SLOT_BITS = 2;
	localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int NUM_CYCLES = 24; // lpc cycles driven over the whole run
	localparam int WATCHDOG_CLOCKS = NUM_CYCLES * 6 * 10 * CLOCKS_PER_BIT + 4000;
	localparam int QUIET_CLOCKS = 30 * CLOCKS_PER_BIT; // three frames of idle line

	logic clock;
	logic rst;
	logic [3:0] lpc_ad;
	logic lpc_frame;
	logic uart_tx;
	logic overflow;

	logic [47:0] exp_q[$]; // records in sending order with byte 0 on top
	logic allow_skip; // dropped records may be missing
	logic rx_busy;
	int sb_errors;
	int chk_errors;
	int rx_records;
	integer seed;

	lpc_sniffer #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE(BAUD_RATE),
		.SLOT_BITS(SLOT_BITS)
	) dut0 (
		.clock(clock), .rst(rst),
		.lpc_ad(lpc_ad), .lpc_frame(lpc_frame),
		.uart_tx(uart_tx), .overflow(overflow)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// ******************************
	// lpc host model
	// ******************************
	task automatic drive_nibble(input logic frame, input logic [3:0] ad);
		@(negedge clock);
		lpc_frame = frame;
		lpc_ad = ad;
	endtask

	task automatic bus_idle(input int n);
		repeat (n) drive_nibble(1'b1, 4'hf);
	endtask

	task automatic lpc_cycle(input logic [3:0] start_nib, input logic [3:0] cyctype,
			input int addr_nibbles, input logic is_write, input logic [31:0] addr,
			input logic [7:0] data);
		drive_nibble(1'b0, start_nib);
		drive_nibble(1'b1, cyctype);
		for (int i = addr_nibbles - 1; i >= 0; i--)
			drive_nibble(1'b1, addr[i*4 +: 4]); // msb nibble first
		if (is_write) begin
			drive_nibble(1'b1, data[3:0]);
			drive_nibble(1'b1, data[7:4]);
			bus_idle(2); // turnaround
			drive_nibble(1'b1, 4'h0); // sync ready
			bus_idle(2);
		end else begin
			bus_idle(2);
			drive_nibble(1'b1, 4'h5); // one short wait
			drive_nibble(1'b1, 4'h0);
			drive_nibble(1'b1, data[3:0]);
			drive_nibble(1'b1, data[7:4]);
			bus_idle(2);
		end
	endtask

	// kind byte, address msb first, data
	task automatic expect_record(input logic [3:0] kind, input logic [31:0] addr,
			input logic [7:0] data);
		exp_q.push_back({4'h0, kind, addr, data});
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		expect_record(4'b0010, {16'h0, addr}, data);
		lpc_cycle(4'h0, 4'b0010, 4, 1'b1, {16'h0, addr}, data);
	endtask

	task automatic io_read(input logic [15:0] addr, input logic [7:0] data);
		expect_record(4'b0000, {16'h0, addr}, data);
		lpc_cycle(4'h0, 4'b0000, 4, 1'b0, {16'h0, addr}, data);
	endtask

	task automatic mem_write(input logic [31:0] addr, input logic [7:0] data);
		expect_record(4'b0110, addr, data);
		lpc_cycle(4'h0, 4'b0110, 8, 1'b1, addr, data);
	endtask

	task automatic mem_read(input logic [31:0] addr, input logic [7:0] data);
		expect_record(4'b0100, addr, data);
		lpc_cycle(4'h0, 4'b0100, 8, 1'b0, addr, data);
	endtask

	task automatic abort_cycle();
		drive_nibble(1'b0, 4'h0);
		drive_nibble(1'b1, 4'b0010);
		drive_nibble(1'b1, 4'h1);
		drive_nibble(1'b1, 4'h2);
		repeat (4) drive_nibble(1'b0, 4'hf); // host abort in mid address
		bus_idle(2);
	endtask

	// ******************************
	// scoreboard
	// ******************************
	task automatic check_record(input logic [47:0] got);
		int hit;
		hit = -1;
		rx_records++;
		if (exp_q.size() == 0) begin
			sb_errors++;
			$display("uart sent record %h at %0t while no lpc cycle was outstanding",
				got, $time);
		end else begin
			if (allow_skip) begin
				for (int i = 0; i < exp_q.size(); i++)
					if (hit < 0 && exp_q[i] == got)
						hit = i;
			end else if (exp_q[0] == got) begin
				hit = 0;
			end
			assert (hit >= 0) else begin
				sb_errors++;
				$display("** Error at %0t: uart_tx record expected %h got %h",
					$time, exp_q[0], got);
			end
			repeat (hit < 0 ? 1 : hit + 1) void'(exp_q.pop_front());
		end
	endtask

	// uart receiver sampling on falling clock edges near mid bit
	initial begin : uart_rx
		logic [7:0] rx_byte;
		logic [47:0] rx_rec;
		int nbytes;
		rx_busy = 1'b0;
		rx_rec = '0;
		nbytes = 0;
		forever begin
			@(negedge clock);
			if (uart_tx === 1'b0) begin
				rx_busy = 1'b1;
				repeat (CLOCKS_PER_BIT / 2) @(negedge clock);
				assert (uart_tx === 1'b0) else begin
					sb_errors++;
					$display("** Error at %0t: uart_tx start bit expected 0 got %b",
						$time, uart_tx);
				end
				for (int i = 0; i < 8; i++) begin
					repeat (CLOCKS_PER_BIT) @(negedge clock);
					rx_byte[i] = uart_tx; // lsb first
				end
				repeat (CLOCKS_PER_BIT) @(negedge clock);
				assert (uart_tx === 1'b1) else begin
					sb_errors++;
					$display("** Error at %0t: uart_tx stop bit expected 1 got %b",
						$time, uart_tx);
				end
				rx_rec = {rx_rec[39:0], rx_byte};
				nbytes++;
				if (nbytes == 6) begin
					check_record(rx_rec);
					nbytes = 0;
				end
				rx_busy = 1'b0;
			end
		end
	end

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clock);
	endtask

	task automatic wait_line_quiet(input int clocks);
		int quiet;
		quiet = 0;
		while (quiet < clocks) begin
			@(negedge clock);
			if (uart_tx === 1'b1 && !rx_busy)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CLOCKS) @(posedge clock);
		$display("watchdog expired after %0d clocks with %0d records still expected",
			WATCHDOG_CLOCKS, exp_q.size());
		$display("Test failures found");
		$finish;
	end

	// ******************************
	// test sequence
	// ******************************
	initial begin : main
		logic [31:0] rnd;
		logic [31:0] rnd2;
		int burst_start;
		seed = 23;
		rst = 1'b1;
		lpc_frame = 1'b1;
		lpc_ad = 4'hf;
		allow_skip = 1'b0;
		sb_errors = 0;
		rx_records = 0;
		repeat (8) @(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		assert (uart_tx === 1'b1) else begin
			sb_errors++;
			$display("** Error at %0t: uart_tx expected 1 got %b", $time, uart_tx);
		end

		io_write(16'h0080, 8'h5a); // post code port
		wait_drain();
		io_read(16'h03f8, 8'hc3);
		wait_drain();

		repeat (2) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			mem_write(rnd, rnd2[7:0]);
			rnd = $random(seed);
			rnd2 = $random(seed);
			mem_read(rnd, rnd2[7:0]);
		end
		wait_drain();

		// cycles that must not produce a record
		abort_cycle();
		lpc_cycle(4'b0101, 4'b0010, 4, 1'b1, 32'h0000_0060, 8'h11); // bad start
		lpc_cycle(4'h0, 4'b1000, 4, 1'b1, 32'h0000_0004, 8'h22); // dma cyctype
		io_write(16'h0064, 8'hfe);
		rnd = $random(seed);
		mem_read(rnd, 8'h3c);
		wait_drain();
		assert (overflow === 1'b0) else begin
			sb_errors++;
			$display("** Error at %0t: overflow expected 0 got %b", $time, overflow);
		end

		// burst against the slow uart
		burst_start = rx_records;
		allow_skip = 1'b1;
		repeat (12) begin
			rnd = $random(seed);
			io_write(rnd[15:0], rnd[23:16]);
		end
		wait_line_quiet(QUIET_CLOCKS);
		assert (overflow === 1'b1) else begin
			sb_errors++;
			$display("** Error at %0t: overflow expected 1 got %b", $time, overflow);
		end
		io_write(16'h0080, 8'haa); // marker that flushes dropped entries
		wait_drain();

		// one full ring of burst records, then the marker
		assert (rx_records - burst_start == (1 << SLOT_BITS) + 1) else begin
			sb_errors++;
			$display("** Error at %0t: burst records received expected %0d got %0d",
				$time, (1 << SLOT_BITS) + 1, rx_records - burst_start);
		end

		chk_errors = dut0.chk0.fail_count;
		$display("scoreboard errors: %0d, assertion errors: %0d, records received: %0d",
			sb_errors, chk_errors, rx_records);
		if (sb_errors == 0 && chk_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- lpc_sniffer.f
lpc_sniffer_pkg.sv
lpc_decoder.sv
capture_writer.sv
ring_ctrl.sv
record_ram.sv
mem_arbiter.sv
record_serializer.sv
uart_tx.sv
lpc_sniffer.sv
lpc_sniffer_chk.sv
tb_lpc_sniffer.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -j 0
TOP = tb_lpc_sniffer
FILELIST = lpc_sniffer.f
SIMFLAGS = +verilator+error+limit+1000
LOG = sim.log
FAIL_MSG = Test failures found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
